// ==== project.f ====
hdl/board_pkg.sv
hdl/reset_sequencer.sv
hdl/ps2_kbd_rx.sv
hdl/key_event_ctrl.sv
hdl/video_timing.sv
hdl/pattern_gen.sv
hdl/board_top.sv
verification/board_top_props.sv
verification/tb_board_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the board testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_board_top -f project.f \
    && ./obj_dir/Vtb_board_top | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/tb_board_top.sv ====
`timescale 1ns/100ps

module tb_board_top;

    localparam int H_ACTIVE     = 16;
    localparam int RESET_CYCLES = 8;
    localparam int PS2_HALF     = 8;   // pixel clocks per PS/2 half period
    localparam int FRAME_CYCLES = (16 + 2 + 2 + 2) * (6 + 1 + 1 + 1);
    localparam int BYTE_CYCLES  = 11 * 2 * PS2_HALF + PS2_HALF + 2;
    localparam int NUM_BYTES    = 17;
    localparam int VIDEO_CHECKS = 4;
    // each video check may wait up to two frames before its window
    localparam int CYCLE_LIMIT  =
        NUM_BYTES * BYTE_CYCLES + VIDEO_CHECKS * 3 * FRAME_CYCLES + 2000;

    logic                   clk_pix;
    logic                   rst_i;
    logic                   clk_locked_i;
    logic                   ps2_clk_i;
    logic                   ps2_data_i;
    board_pkg::scan_code_t  led_o;
    logic                   kbd_err_o;
    board_pkg::key_event_t  key_event_o;
    logic                   key_strobe_o;
    board_pkg::rgb_t        rgb_o;
    board_pkg::video_sync_t sync_o;

    int                    errors;
    int                    check_cnt;
    int                    tests_run;
    int                    cycle_cnt;
    int                    byte_cnt;
    int                    err_cnt;
    int                    key_cnt;
    board_pkg::key_event_t last_event;
    board_pkg::scan_code_t exp_led;
    logic                  exp_invert;
    logic [15:0]           lfsr_q;

    board_top #(
        .RESET_CYCLES (RESET_CYCLES),
        .FRAME_TIMEOUT(200),
        .H_ACTIVE     (H_ACTIVE),
        .H_FRONT      (2),
        .H_SYNC       (2),
        .H_BACK       (2),
        .V_ACTIVE     (6),
        .V_FRONT      (1),
        .V_SYNC       (1),
        .V_BACK       (1)
    ) dut_i (
        .clk_pix     (clk_pix),
        .rst_i       (rst_i),
        .clk_locked_i(clk_locked_i),
        .ps2_clk_i   (ps2_clk_i),
        .ps2_data_i  (ps2_data_i),
        .led_o       (led_o),
        .kbd_err_o   (kbd_err_o),
        .key_event_o (key_event_o),
        .key_strobe_o(key_strobe_o),
        .rgb_o       (rgb_o),
        .sync_o      (sync_o)
    );

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;
    end

    // strobe counters, sampled mid cycle
    always @(negedge clk_pix) begin
        if (dut_i.code_strobe) byte_cnt++;
        if (kbd_err_o) err_cnt++;
        if (key_strobe_o) begin
            key_cnt++;
            last_event = key_event_o;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_pix);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_pix);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_code(output board_pkg::scan_code_t code);
        int i;
        code = '0;
        do begin
            for (i = 0; i < 8; i++) begin
                lfsr_q = lfsr_next(lfsr_q);   // one step per bit
                code   = {code[6:0], lfsr_q[0]};
            end
        end while (code == board_pkg::CODE_EXT || code == board_pkg::CODE_REL ||
                   code == board_pkg::CODE_SPACE);
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_frame(input board_pkg::scan_code_t code, input logic bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data_i = bits[i];
            wait_cycles(PS2_HALF);
            ps2_clk_i = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk_i = 1'b1;
        end
        wait_cycles(PS2_HALF);
    endtask

    task automatic send_byte(input board_pkg::scan_code_t code, input logic bad_parity);
        int b0;
        int e0;
        int n;
        b0 = byte_cnt;
        e0 = err_cnt;
        n  = 0;
        send_frame(code, bad_parity);
        while (byte_cnt == b0 && err_cnt == e0 && n < 40) begin
            wait_cycles(1);
            n++;
        end
        if (byte_cnt == b0 && err_cnt == e0) begin
            $display("keyboard receiver gave no strobe after a frame at %0t ns", $time);
            errors++;
        end
        wait_cycles(2);   // key event follows one cycle later
    endtask

    task automatic send_key(input board_pkg::scan_code_t code, input logic ext, input logic rel);
        int k0;
        k0 = key_cnt;
        if (ext) send_byte(board_pkg::CODE_EXT, 1'b0);
        if (rel) send_byte(board_pkg::CODE_REL, 1'b0);
        send_byte(code, 1'b0);
        if (!rel) begin
            exp_led = code;
            if (code == board_pkg::CODE_SPACE) exp_invert = !exp_invert;
        end
        check("key strobe count", key_cnt, k0 + 1);
        check("key_event_o.released", 32'(last_event.released), 32'(rel));
        check("key_event_o.extended", 32'(last_event.extended), 32'(ext));
        check("key_event_o.code", 32'(last_event.code), 32'(code));
        check("led_o", 32'(led_o), 32'(exp_led));
    endtask

    function automatic board_pkg::rgb_t bar_colour(input int pos, input logic inv);
        logic [2:0]      lit;
        board_pkg::rgb_t c;
        lit = 3'((pos * 8) / H_ACTIVE) ^ {3{inv}};
        c.r = lit[0] ? 4'hF : 4'h0;
        c.g = lit[1] ? 4'hF : 4'h0;
        c.b = lit[2] ? 4'hF : 4'h0;
        return c;
    endfunction

    // one frame window starting at the vsync falling edge
    task automatic check_video_frame(input logic inv);
        board_pkg::video_sync_t prev;
        int n, i, de_run, de_lines, hs_falls, vs_falls;
        n = 0;
        de_run = 0;
        de_lines = 0;
        hs_falls = 0;
        vs_falls = 0;
        prev = sync_o;
        wait_cycles(1);
        while (!(prev.vsync_n && !sync_o.vsync_n) && n < 2 * FRAME_CYCLES) begin
            prev = sync_o;
            wait_cycles(1);
            n++;
        end
        if (!(prev.vsync_n && !sync_o.vsync_n)) begin
            $display("no vsync pulse found within two frames at %0t ns", $time);
            errors++;
            return;
        end
        for (i = 0; i < FRAME_CYCLES; i++) begin
            if (prev.hsync_n && !sync_o.hsync_n) hs_falls++;
            if (prev.vsync_n && !sync_o.vsync_n) vs_falls++;
            if (sync_o.de) begin
                if (!prev.de) begin
                    de_run = 0;
                    de_lines++;
                end
                check("rgb_o", 32'(rgb_o), 32'(bar_colour(de_run, inv)));
                de_run++;
            end else if (prev.de) begin
                check("de cycles per line", de_run, H_ACTIVE);
            end
            prev = sync_o;
            wait_cycles(1);
        end
        check("de lines", de_lines, 6);
        check("hsync pulses", hs_falls, 9);
        check("vsync pulses", vs_falls, 1);
    endtask

    task automatic reset_and_lock();
        int e0;
        int n;
        e0 = errors;
        wait_cycles(4);
        rst_i = 1'b0;
        repeat (20) begin
            wait_cycles(1);
            check("led_o", 32'(led_o), 32'h0);
            check("sync_o.de", 32'(sync_o.de), 32'h0);
        end
        clk_locked_i = 1'b1;
        n = 0;
        while (!sync_o.de && n < RESET_CYCLES + 2 * FRAME_CYCLES) begin
            wait_cycles(1);
            n++;
        end
        if (!sync_o.de) begin
            $display("video never started after clock lock");
            errors++;
        end else if (n < RESET_CYCLES) begin
            $display("video started before the reset delay had elapsed");
            errors++;
        end
        check("led_o", 32'(led_o), 32'h0);
        report_test("reset and lock", e0);
    endtask

    task automatic make_codes();
        board_pkg::scan_code_t code;
        int e0;
        e0 = errors;
        repeat (4) begin
            random_code(code);
            send_key(code, 1'b0, 1'b0);
        end
        report_test("make codes", e0);
    endtask

    task automatic prefix_codes();
        board_pkg::scan_code_t code;
        int e0;
        e0 = errors;
        random_code(code);
        send_key(code, 1'b1, 1'b0);
        random_code(code);
        send_key(code, 1'b0, 1'b1);   // led_o keeps the last make
        random_code(code);
        send_key(code, 1'b1, 1'b1);
        report_test("prefixes", e0);
    endtask

    task automatic parity_error();
        board_pkg::scan_code_t code;
        int e0;
        int k0;
        int r0;
        e0 = errors;
        k0 = key_cnt;
        r0 = err_cnt;
        random_code(code);
        send_byte(code, 1'b1);
        check("kbd_err_o pulses", err_cnt, r0 + 1);
        check("key strobe count", key_cnt, k0);
        check("led_o", 32'(led_o), 32'(exp_led));
        random_code(code);
        send_key(code, 1'b0, 1'b0);
        report_test("parity error", e0);
    endtask

    task automatic video_frame();
        int e0;
        e0 = errors;
        check_video_frame(exp_invert);
        report_test("video frame", e0);
    endtask

    task automatic invert_toggle();
        int e0;
        e0 = errors;
        send_key(board_pkg::CODE_SPACE, 1'b0, 1'b0);
        check_video_frame(exp_invert);
        send_key(board_pkg::CODE_SPACE, 1'b0, 1'b1);   // break leaves it inverted
        check_video_frame(exp_invert);
        send_key(board_pkg::CODE_SPACE, 1'b0, 1'b0);
        check_video_frame(exp_invert);
        report_test("invert", e0);
    endtask

    initial begin
        rst_i        = 1'b1;
        clk_locked_i = 1'b0;
        ps2_clk_i    = 1'b1;
        ps2_data_i   = 1'b1;
        errors       = 0;
        check_cnt    = 0;
        tests_run    = 0;
        byte_cnt     = 0;
        err_cnt      = 0;
        key_cnt      = 0;
        last_event   = '0;
        exp_led      = '0;
        exp_invert   = 1'b0;
        lfsr_q       = 16'd79;
        reset_and_lock();
        make_codes();
        prefix_codes();
        parity_error();
        video_frame();
        invert_toggle();
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_cnt, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/board_top_props.sv ====
`timescale 1ns/100ps

module board_top_props (
    input logic                   clk_pix,
    input logic                   sys_rst_i,
    input logic                   code_strobe_i,
    input logic                   frame_err_i,
    input logic                   key_strobe_i,
    input board_pkg::rgb_t        rgb_i,
    input board_pkg::video_sync_t sync_i
);

    logic armed = 1'b0;   // set once the internal reset has been seen

    always_ff @(posedge clk_pix) begin
        if (sys_rst_i) armed <= 1'b1;
    end

    sync_idle_in_reset: assert property (@(posedge clk_pix) disable iff (!armed)
        sys_rst_i |=> (sync_i.hsync_n && sync_i.vsync_n && !sync_i.de))
        else $error("video sync active during internal reset");

    strobes_exclusive: assert property (@(posedge clk_pix) disable iff (!armed)
        !(code_strobe_i && frame_err_i))
        else $error("code strobe and frame error high together");

    key_after_code: assert property (@(posedge clk_pix) disable iff (!armed)
        key_strobe_i |-> $past(code_strobe_i))
        else $error("key strobe without a code strobe one cycle earlier");

    black_outside_de: assert property (@(posedge clk_pix) disable iff (!armed)
        !sync_i.de |-> (rgb_i == '0))
        else $error("colour present while de is low");

endmodule

bind board_top board_top_props props_i (
    .clk_pix      (clk_pix),
    .sys_rst_i    (sys_rst),
    .code_strobe_i(code_strobe),
    .frame_err_i  (frame_err),
    .key_strobe_i (key_strobe_o),
    .rgb_i        (rgb_o),
    .sync_i       (sync_o)
);

// ==== hdl/board_top.sv ====
`timescale 1ns/100ps

module board_top #(
    parameter int RESET_CYCLES  = 32,
    parameter int FRAME_TIMEOUT = 20000,
    parameter int H_ACTIVE      = 640,
    parameter int H_FRONT       = 16,
    parameter int H_SYNC        = 96,
    parameter int H_BACK        = 48,
    parameter int V_ACTIVE      = 480,
    parameter int V_FRONT       = 10,
    parameter int V_SYNC        = 2,
    parameter int V_BACK        = 33
) (
    input  logic                   clk_pix,
    input  logic                   rst_i,
    input  logic                   clk_locked_i,
    input  logic                   ps2_clk_i,
    input  logic                   ps2_data_i,
    output board_pkg::scan_code_t  led_o,
    output logic                   kbd_err_o,
    output board_pkg::key_event_t  key_event_o,
    output logic                   key_strobe_o,
    output board_pkg::rgb_t        rgb_o,
    output board_pkg::video_sync_t sync_o
);

    logic                   sys_rst;
    board_pkg::scan_code_t  code;
    logic                   code_strobe;
    logic                   frame_err;
    logic                   invert;
    board_pkg::coord_t      x;
    board_pkg::coord_t      y;
    board_pkg::video_sync_t sync;

    assign kbd_err_o = frame_err;

    reset_sequencer #(
        .RESET_CYCLES(RESET_CYCLES)
    ) reset_sequencer_i (
        .clk_pix     (clk_pix),
        .rst_i       (rst_i),
        .clk_locked_i(clk_locked_i),
        .sys_rst_o   (sys_rst)
    );

    // keyboard path
    ps2_kbd_rx #(
        .FRAME_TIMEOUT(FRAME_TIMEOUT)
    ) ps2_kbd_rx_i (
        .clk_pix      (clk_pix),
        .rst_i        (sys_rst),
        .ps2_clk_i    (ps2_clk_i),
        .ps2_data_i   (ps2_data_i),
        .code_o       (code),
        .code_strobe_o(code_strobe),
        .frame_err_o  (frame_err)
    );

    key_event_ctrl key_event_ctrl_i (
        .clk_pix       (clk_pix),
        .rst_i         (sys_rst),
        .code_i        (code),
        .code_strobe_i (code_strobe),
        .frame_err_i   (frame_err),
        .event_o       (key_event_o),
        .event_strobe_o(key_strobe_o),
        .led_o         (led_o),
        .invert_o      (invert)
    );

    // video path
    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) video_timing_i (
        .clk_pix(clk_pix),
        .rst_i  (sys_rst),
        .x_o    (x),
        .y_o    (y),
        .sync_o (sync)
    );

    pattern_gen #(
        .H_ACTIVE(H_ACTIVE)
    ) pattern_gen_i (
        .clk_pix (clk_pix),
        .rst_i   (sys_rst),
        .x_i     (x),
        .y_i     (y),
        .sync_i  (sync),
        .invert_i(invert),
        .rgb_o   (rgb_o),
        .sync_o  (sync_o)
    );

endmodule

// ==== hdl/pattern_gen.sv ====
`timescale 1ns/100ps

module pattern_gen #(
    parameter int H_ACTIVE = 640
) (
    input  logic                   clk_pix,
    input  logic                   rst_i,
    input  board_pkg::coord_t      x_i,
    input  board_pkg::coord_t      y_i,
    input  board_pkg::video_sync_t sync_i,
    input  logic                   invert_i,
    output board_pkg::rgb_t        rgb_o,
    output board_pkg::video_sync_t sync_o
);

    logic [2:0]      bar;
    logic [2:0]      lit;
    logic            in_frame;
    board_pkg::rgb_t rgb_next;

    // eight equal bars across the active width
    assign bar = 3'((32'(x_i) * 8) / H_ACTIVE);
    assign lit = bar ^ {3{invert_i}};

    assign in_frame = sync_i.de && (x_i < board_pkg::coord_t'(H_ACTIVE));

    always_comb begin
        rgb_next.r = {4{lit[0]}};
        rgb_next.g = {4{lit[1]}};
        rgb_next.b = {4{lit[2]}};
        if (!in_frame) begin
            rgb_next = '0;   // black outside active video
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_i) begin
            rgb_o  <= '0;
            sync_o <= '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0};
        end else begin
            rgb_o  <= rgb_next;
            sync_o <= sync_i;
        end
    end

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                   clk_pix,
    input  logic                   rst_i,
    output board_pkg::coord_t      x_o,
    output board_pkg::coord_t      y_o,
    output board_pkg::video_sync_t sync_o
);

    localparam board_pkg::coord_t H_ACT_END = board_pkg::coord_t'(H_ACTIVE);
    localparam board_pkg::coord_t H_SYNC_BEG = board_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam board_pkg::coord_t H_SYNC_END = board_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam board_pkg::coord_t H_LAST =
        board_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

    localparam board_pkg::coord_t V_ACT_END = board_pkg::coord_t'(V_ACTIVE);
    localparam board_pkg::coord_t V_SYNC_BEG = board_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam board_pkg::coord_t V_SYNC_END = board_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam board_pkg::coord_t V_LAST =
        board_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    board_pkg::coord_t      h_next;
    board_pkg::coord_t      v_next;
    board_pkg::video_sync_t sync_next;

    always_comb begin
        h_next = x_o + 1'b1;
        v_next = y_o;
        if (x_o == H_LAST) begin
            h_next = '0;
            v_next = (y_o == V_LAST) ? '0 : y_o + 1'b1;
        end
    end

    // sync decoded from the next position so it lines up with x and y
    always_comb begin
        sync_next.hsync_n = !(h_next >= H_SYNC_BEG && h_next < H_SYNC_END);
        sync_next.vsync_n = !(v_next >= V_SYNC_BEG && v_next < V_SYNC_END);
        sync_next.de      = (h_next < H_ACT_END) && (v_next < V_ACT_END);
    end

    always_ff @(posedge clk_pix) begin
        if (rst_i) begin
            // park on the last back porch pixel, first step lands on 0,0
            x_o    <= H_LAST;
            y_o    <= V_LAST;
            sync_o <= '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0};
        end else begin
            x_o    <= h_next;
            y_o    <= v_next;
            sync_o <= sync_next;
        end
    end

endmodule

// ==== hdl/key_event_ctrl.sv ====
`timescale 1ns/100ps

module key_event_ctrl (
    input  logic                  clk_pix,
    input  logic                  rst_i,
    input  board_pkg::scan_code_t code_i,
    input  logic                  code_strobe_i,
    input  logic                  frame_err_i,
    output board_pkg::key_event_t event_o,
    output logic                  event_strobe_o,
    output board_pkg::scan_code_t led_o,
    output logic                  invert_o
);

    board_pkg::key_state_e state_q;
    board_pkg::key_state_e state_next;
    logic                  is_prefix;
    logic                  ext_seen;
    logic                  rel_seen;
    logic                  emit;

    assign ext_seen = (state_q == board_pkg::ST_EXT) || (state_q == board_pkg::ST_EXT_REL);
    assign rel_seen = (state_q == board_pkg::ST_REL) || (state_q == board_pkg::ST_EXT_REL);

    assign is_prefix = (code_i == board_pkg::CODE_EXT) || (code_i == board_pkg::CODE_REL);
    assign emit      = code_strobe_i && !frame_err_i && !is_prefix;

    always_comb begin
        state_next = state_q;
        if (frame_err_i) begin
            state_next = board_pkg::ST_IDLE;
        end else if (code_strobe_i) begin
            if (code_i == board_pkg::CODE_EXT) begin
                state_next = rel_seen ? board_pkg::ST_EXT_REL : board_pkg::ST_EXT;
            end else if (code_i == board_pkg::CODE_REL) begin
                state_next = ext_seen ? board_pkg::ST_EXT_REL : board_pkg::ST_REL;
            end else begin
                state_next = board_pkg::ST_IDLE;   // final byte ends the sequence
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_i) begin
            state_q        <= board_pkg::ST_IDLE;
            event_strobe_o <= 1'b0;
            led_o          <= '0;
            invert_o       <= 1'b0;
        end else begin
            state_q        <= state_next;
            event_strobe_o <= emit;
            if (emit && !rel_seen) begin
                led_o <= code_i;   // make codes only
                if (code_i == board_pkg::CODE_SPACE) begin
                    invert_o <= !invert_o;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (emit) begin
            event_o.released <= rel_seen;
            event_o.extended <= ext_seen;
            event_o.code     <= code_i;
        end
    end

endmodule

// ==== hdl/ps2_kbd_rx.sv ====
`timescale 1ns/100ps

module ps2_kbd_rx #(
    parameter int FRAME_TIMEOUT = 20000
) (
    input  logic                  clk_pix,
    input  logic                  rst_i,
    input  logic                  ps2_clk_i,
    input  logic                  ps2_data_i,
    output board_pkg::scan_code_t code_o,
    output logic                  code_strobe_o,
    output logic                  frame_err_o
);

    localparam int TW = $clog2(FRAME_TIMEOUT + 1);
    localparam logic [TW-1:0] TIMEOUT_LAST = TW'(FRAME_TIMEOUT - 1);

    logic [1:0]    clk_sync_q;
    logic [1:0]    data_sync_q;
    logic          clk_prev_q;
    logic          clk_fall;
    logic [9:0]    shift_q;     // first ten bits, start bit ends up in bit 0
    logic [3:0]    bit_cnt_q;
    logic [TW-1:0] idle_cnt_q;
    logic [10:0]   frame;
    logic          frame_ok;

    // two-flop synchronizers, then edge detect
    always_ff @(posedge clk_pix) begin
        if (rst_i) begin
            clk_sync_q  <= 2'b11;
            data_sync_q <= 2'b11;
            clk_prev_q  <= 1'b1;
        end else begin
            clk_sync_q  <= {clk_sync_q[0], ps2_clk_i};
            data_sync_q <= {data_sync_q[0], ps2_data_i};
            clk_prev_q  <= clk_sync_q[1];
        end
    end

    assign clk_fall = clk_prev_q && !clk_sync_q[1];

    // stop bit arrives live, the rest from the shifter
    assign frame = {data_sync_q[1], shift_q};

    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);   // odd parity

    always_ff @(posedge clk_pix) begin
        if (clk_fall) begin
            shift_q <= {data_sync_q[1], shift_q[9:1]};
        end
    end

    always_ff @(posedge clk_pix) begin
        if (clk_fall && bit_cnt_q == 4'd10) begin
            code_o <= frame[8:1];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_i) begin
            bit_cnt_q     <= '0;
            idle_cnt_q    <= '0;
            code_strobe_o <= 1'b0;
            frame_err_o   <= 1'b0;
        end else begin
            code_strobe_o <= 1'b0;
            frame_err_o   <= 1'b0;
            if (clk_fall) begin
                idle_cnt_q <= '0;
                if (bit_cnt_q == 4'd10) begin
                    bit_cnt_q     <= '0;
                    code_strobe_o <= frame_ok;
                    frame_err_o   <= !frame_ok;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end else if (clk_sync_q[1] && bit_cnt_q != 4'd0) begin
                // stalled frame, drop it
                if (idle_cnt_q == TIMEOUT_LAST) begin
                    bit_cnt_q  <= '0;
                    idle_cnt_q <= '0;
                end else begin
                    idle_cnt_q <= idle_cnt_q + 1'b1;
                end
            end else begin
                idle_cnt_q <= '0;
            end
        end
    end

endmodule

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/100ps

module reset_sequencer #(
    parameter int RESET_CYCLES = 32
) (
    input  logic clk_pix,
    input  logic rst_i,
    input  logic clk_locked_i,
    output logic sys_rst_o
);

    localparam int CW = $clog2(RESET_CYCLES + 1);
    localparam logic [CW-1:0] LAST = CW'(RESET_CYCLES - 1);

    logic          hold;
    logic [CW-1:0] cnt_q;

    // external reset or no lock restarts the delay
    assign hold = rst_i || !clk_locked_i;

    always_ff @(posedge clk_pix) begin
        if (hold) begin
            cnt_q     <= '0;
            sys_rst_o <= 1'b1;
        end else if (sys_rst_o) begin
            if (cnt_q == LAST) begin
                sys_rst_o <= 1'b0;   // released after RESET_CYCLES free cycles
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/board_pkg.sv ====
package board_pkg;

    // one PS/2 data byte
    typedef logic [7:0] scan_code_t;

    // decoded key, flags come from the prefix bytes
    typedef struct packed {
        logic       released;   // preceded by F0
        logic       extended;   // preceded by E0
        scan_code_t code;
    } key_event_t;

    typedef logic [3:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // sync bits are active low
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic de;
    } video_sync_t;

    typedef logic [11:0] coord_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXT,
        ST_REL,
        ST_EXT_REL
    } key_state_e;

    localparam scan_code_t CODE_EXT   = 8'hE0;
    localparam scan_code_t CODE_REL   = 8'hF0;
    localparam scan_code_t CODE_SPACE = 8'h29;

endpackage
